/* src.f */
logic/cache_pkg.sv
logic/tag_store.sv
logic/refill_fifo.sv
logic/mem_port.sv
logic/cache_ctrl.sv
logic/cache_top.sv
bench/cache_assert.sv
bench/cache_tb.sv

/* Makefile */
# Verilator build and run of the cache testbench

VERILATOR ?= verilator
TOP       ?= cache_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Finished with no errors

SRCS := $(wildcard logic/*.sv bench/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when the file list or a source changes
$(BIN): src.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f src.f

run: $(BIN)
	$(BIN) | tee /dev/stderr | grep -xF "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

/* bench/cache_tb.sv */
module cache_tb
	import cache_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int n_cold   = 8;	// cold reads after reset
	localparam int n_random = 300;
	localparam int n_ops    = n_cold + 3 + 10 + n_random;	// core accesses over all tests
	localparam int op_limit = 200;	// clocks allowed per access

	logic      clock_i = 1'b0;
	logic      resetn_i;
	logic      core_req_i;
	core_cmd_t core_cmd_i;
	logic      core_ack_o;
	word_t     core_rdata_o;
	logic      mem_req_o;
	mem_cmd_t  mem_cmd_o;
	logic      mem_ack_i;
	word_t     mem_rdata_i;

	word_t  mem_model [1 << addr_w];
	word_t  shadow [logic [addr_w-1:0]];	// last write per address
	word_t  expect_q [$];	// expected read data in issue order
	integer seed = 32'hd804;
	int     errors = 0;
	int     checks = 0;
	logic   ack_seen = 1'b0;	// core_ack_o at previous negedge

	cache_top #(.lines(4), .depth(2)) i_dut (
		.clock_i(clock_i), .resetn_i(resetn_i),
		.core_req_i(core_req_i), .core_cmd_i(core_cmd_i),
		.core_ack_o(core_ack_o), .core_rdata_o(core_rdata_o),
		.mem_req_o(mem_req_o), .mem_cmd_o(mem_cmd_o),
		.mem_ack_i(mem_ack_i), .mem_rdata_i(mem_rdata_i)
	);

	always #50 clock_i = ~clock_i;

	// every address bit shows up in the initial memory word
	function automatic word_t init_pattern(input logic [addr_w-1:0] addr);
		return {addr ^ 16'ha5c3, ~addr};
	endfunction

	// last write to an address wins or else the memory pattern
	function automatic word_t expected_read(input logic [addr_w-1:0] addr);
		if (shadow.exists(addr))
			return shadow[addr];
		return init_pattern(addr);
	endfunction

	task automatic finish_run();
		int asserts;
		asserts = i_dut.i_assert.fails;	// bound checker
		$display("%0d checks, %0d errors, %0d assertion failures",
			checks, errors, asserts);
		if (errors == 0 && asserts == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	endtask

	// one four-phase core access with clocks counted from req to ack
	task automatic core_access(input logic rw, input logic [addr_w-1:0] addr,
			input word_t wdata, output int clocks);
		clocks = 0;
		if (rw)
			shadow[addr] = wdata;
		else
			expect_q.push_back(expected_read(addr));
		core_cmd_i.rw = rw;
		core_cmd_i.addr.flat = addr;
		core_cmd_i.wdata = wdata;
		core_req_i = 1'b1;
		do begin
			@(posedge clock_i);
			#1;
			clocks++;
		end while (!core_ack_o);
		core_req_i = 1'b0;	// release and wait for ack to drop
		do begin
			@(posedge clock_i);
			#1;
		end while (core_ack_o);
	endtask

	// -----------------------------------------------------------------------
	// memory model with a random ack delay of 0..3 clocks
	initial begin : memory_model
		int delay;
		mem_ack_i = 1'b0;
		mem_rdata_i = '0;
		for (int a = 0; a < (1 << addr_w); a++)
			mem_model[a] = init_pattern(addr_w'(a));
		forever begin
			@(posedge clock_i);
			#1;
			if (mem_req_o) begin
				delay = $unsigned($random(seed)) % 4;
				repeat (delay) begin
					@(posedge clock_i);
					#1;
				end
				if (mem_cmd_o.rw)
					mem_model[mem_cmd_o.addr.flat] = mem_cmd_o.wdata;
				else
					mem_rdata_i = mem_model[mem_cmd_o.addr.flat];
				mem_ack_i = 1'b1;
				do begin	// hold ack until the port lets go
					@(posedge clock_i);
					#1;
				end while (mem_req_o);
				mem_ack_i = 1'b0;
			end
		end
	end

	// read data compared on each rising core_ack_o
	always @(negedge clock_i) begin : read_checker
		word_t exp_data;
		if (resetn_i && core_ack_o && !ack_seen && !core_cmd_i.rw) begin
			if (expect_q.size() == 0) begin
				errors++;
				$display("read acknowledged with no read outstanding");
			end else begin
				exp_data = expect_q.pop_front();
				checks++;
				if (core_rdata_o !== exp_data) begin
					errors++;
					$display("error core_rdata_o at %h: got %h expected %h",
						core_cmd_i.addr.flat, core_rdata_o, exp_data);
				end
			end
		end
		ack_seen = core_ack_o;
	end

	initial begin : watchdog
		repeat (n_ops * op_limit) @(posedge clock_i);
		errors++;
		$display("run stuck, watchdog expired after %0d clocks", n_ops * op_limit);
		finish_run();
	end

	// -----------------------------------------------------------------------
	initial begin : stimulus
		int                clocks;
		logic              rw;
		logic [addr_w-1:0] addr;
		word_t             data;
		logic [addr_w-1:0] wr_addr [5];
		word_t             wr_data [5];
		resetn_i = 1'b0;
		core_req_i = 1'b0;
		core_cmd_i = '0;
		repeat (4) @(posedge clock_i);
		#1;
		resetn_i = 1'b1;

		for (int i = 0; i < n_cold; i++)	// all refills from memory
			core_access(1'b0, 16'h0100 + addr_w'(i * 5), '0, clocks);

		// write miss and two reads that must hit
		core_access(1'b1, 16'h0402, 32'hcafe_0402, clocks);
		for (int i = 0; i < 2; i++) begin
			core_access(1'b0, 16'h0402, '0, clocks);
			checks++;
			if (clocks != 2) begin
				errors++;
				$display("hit read took %0d clocks to acknowledge instead of 2", clocks);
			end
		end

		// five fresh lines into four so the first of them is written back
		for (int i = 0; i < 5; i++) begin
			wr_addr[i] = 16'h2000 + addr_w'(i * 16 + i);
			wr_data[i] = $random(seed);
			core_access(1'b1, wr_addr[i], wr_data[i], clocks);
		end
		checks++;
		if (mem_model[wr_addr[0]] !== wr_data[0]) begin
			errors++;
			$display("error mem_model[%h] after eviction: got %h expected %h",
				wr_addr[0], mem_model[wr_addr[0]], wr_data[0]);
		end
		for (int i = 0; i < 5; i++)
			core_access(1'b0, wr_addr[i], '0, clocks);

		// random mix over 8 lines
		for (int i = 0; i < n_random; i++) begin
			rw = 1'($random(seed));
			addr = 16'h3000 + addr_w'($unsigned($random(seed)) % 32);
			data = $random(seed);
			core_access(rw, addr, data, clocks);
		end
		finish_run();
	end

endmodule

/* bench/cache_assert.sv */
module cache_assert
	import cache_pkg::*;
(
	input logic     clock_i,
	input logic     resetn_i,
	input logic     core_req_i,
	input logic     core_ack_o,
	input logic     mem_req_o,
	input mem_cmd_t mem_cmd_o,
	input logic     mem_ack_i
);

	timeunit 1ns;
	timeprecision 100ps;

	int fails = 0;	// failed assertions so far

	// -----------------------------------------------------------------------
	// core side
	core_ack_needs_req: assert property (@(posedge clock_i) disable iff (!resetn_i)
		!core_ack_o && !core_req_i |=> !core_ack_o)
		else begin
			$error("core_ack_o rose while core_req_i was low");
			fails++;
		end

	// memory side
	// command held for the whole request
	mem_cmd_stable: assert property (@(posedge clock_i) disable iff (!resetn_i)
		mem_req_o |=> !mem_req_o || $stable(mem_cmd_o))
		else begin
			$error("mem_cmd_o changed while mem_req_o was high");
			fails++;
		end

	mem_req_held: assert property (@(posedge clock_i) disable iff (!resetn_i)
		mem_req_o && !mem_ack_i |=> mem_req_o)	// no early release
		else begin
			$error("mem_req_o fell before mem_ack_i rose");
			fails++;
		end

	quiet_after_reset: assert property (@(posedge clock_i)
		!resetn_i |=> !core_ack_o && !mem_req_o)
		else begin
			$error("core_ack_o or mem_req_o high after reset");
			fails++;
		end

endmodule

bind cache_top cache_assert i_assert (
	.clock_i(clock_i), .resetn_i(resetn_i),
	.core_req_i(core_req_i), .core_ack_o(core_ack_o),
	.mem_req_o(mem_req_o), .mem_cmd_o(mem_cmd_o), .mem_ack_i(mem_ack_i)
);

/* logic/cache_top.sv */
module cache_top
	import cache_pkg::*;
#(
	parameter int lines = 4,
	parameter int depth = 2
)(
	input  logic      clock_i,
	input  logic      resetn_i,
	// core
	input  logic      core_req_i,
	input  core_cmd_t core_cmd_i,
	output logic      core_ack_o,
	output word_t     core_rdata_o,
	// external memory
	output logic      mem_req_o,
	output mem_cmd_t  mem_cmd_o,
	input  logic      mem_ack_i,
	input  word_t     mem_rdata_i
);

	localparam int idx_w = $clog2(lines);

	// controller <-> tag store
	tag_t             lookup_tag;
	logic             hit;
	logic [idx_w-1:0] hit_line;
	logic             mark_dirty;
	logic             fill;
	tag_t             fill_tag;
	logic [idx_w-1:0] victim_line;
	logic             victim_valid;
	logic             victim_dirty;
	tag_t             victim_tag;

	// controller <-> memory port, refill path
	logic  job_req;
	job_t  job;
	logic  job_ack;
	logic  fifo_full;
	logic  fifo_push;
	word_t fifo_wdata;
	logic  fifo_empty;
	logic  fifo_pop;
	word_t fifo_rdata;

	// -------------------------------------------------------------------------
	cache_ctrl #(.lines(lines)) i_ctrl (
		.clock_i(clock_i), .resetn_i(resetn_i),
		.core_req_i(core_req_i), .core_cmd_i(core_cmd_i),
		.core_ack_o(core_ack_o), .core_rdata_o(core_rdata_o),
		.lookup_tag_o(lookup_tag), .hit_i(hit), .hit_line_i(hit_line),
		.mark_dirty_o(mark_dirty), .fill_o(fill), .fill_tag_o(fill_tag),
		.victim_line_i(victim_line), .victim_valid_i(victim_valid),
		.victim_dirty_i(victim_dirty), .victim_tag_i(victim_tag),
		.job_req_o(job_req), .job_o(job), .job_ack_i(job_ack),
		.fifo_empty_i(fifo_empty), .fifo_pop_o(fifo_pop), .fifo_data_i(fifo_rdata)
	);

	tag_store #(.lines(lines)) i_tags (
		.clock_i(clock_i), .resetn_i(resetn_i),
		.lookup_tag_i(lookup_tag), .hit_o(hit), .hit_line_o(hit_line),
		.mark_dirty_i(mark_dirty), .fill_i(fill), .fill_tag_i(fill_tag),
		.victim_line_o(victim_line), .victim_valid_o(victim_valid),
		.victim_dirty_o(victim_dirty), .victim_tag_o(victim_tag)
	);

	mem_port i_port (
		.clock_i(clock_i), .resetn_i(resetn_i),
		.job_req_i(job_req), .job_i(job), .job_ack_o(job_ack),
		.fifo_full_i(fifo_full), .fifo_push_o(fifo_push), .fifo_data_o(fifo_wdata),
		.mem_req_o(mem_req_o), .mem_cmd_o(mem_cmd_o),
		.mem_ack_i(mem_ack_i), .mem_rdata_i(mem_rdata_i)
	);

	refill_fifo #(.depth(depth)) i_fifo (
		.clock_i(clock_i), .resetn_i(resetn_i),
		.push_i(fifo_push), .push_data_i(fifo_wdata), .full_o(fifo_full),
		.pop_i(fifo_pop), .pop_data_o(fifo_rdata), .empty_o(fifo_empty)
	);

endmodule

/* logic/cache_ctrl.sv */
module cache_ctrl
	import cache_pkg::*;
#(
	parameter int lines = 4
)(
	input  logic                     clock_i,
	input  logic                     resetn_i,
	// core side
	input  logic                     core_req_i,
	input  core_cmd_t                core_cmd_i,	// held stable while req is high
	output logic                     core_ack_o,
	output word_t                    core_rdata_o,
	// tag store
	output tag_t                     lookup_tag_o,
	input  logic                     hit_i,
	input  logic [$clog2(lines)-1:0] hit_line_i,
	output logic                     mark_dirty_o,
	output logic                     fill_o,
	output tag_t                     fill_tag_o,
	input  logic [$clog2(lines)-1:0] victim_line_i,
	input  logic                     victim_valid_i,
	input  logic                     victim_dirty_i,
	input  tag_t                     victim_tag_i,
	// memory port jobs
	output logic                     job_req_o,
	output job_t                     job_o,
	input  logic                     job_ack_i,
	// refill fifo
	input  logic                     fifo_empty_i,
	output logic                     fifo_pop_o,
	input  word_t                    fifo_data_i
);

	typedef enum logic [2:0] {c_idle, c_wb, c_rreq, c_drain, c_ack} ctrl_state_t;

	ctrl_state_t         state;
	logic [offset_w-1:0] word_cnt;	// word of the line in writeback / drain
	logic [offset_w-1:0] req_offset;
	word_t               data_mem [lines][1 << offset_w];
	logic                serve;	// idle with a pending request
	logic                line_hit;
	logic                job_free;	// previous job handshake fully closed
	logic                wb_issue;
	logic                rf_issue;

	assign req_offset   = core_cmd_i.addr.fields.offset;
	assign lookup_tag_o = core_cmd_i.addr.fields.tag;
	assign fill_tag_o   = core_cmd_i.addr.fields.tag;	// missed tag goes to the victim

	assign serve        = (state == c_idle) && core_req_i;
	assign line_hit     = serve && hit_i;
	assign mark_dirty_o = line_hit && core_cmd_i.rw;
	assign job_free     = !job_req_o && !job_ack_i;
	assign wb_issue     = (state == c_wb) && job_free;
	assign rf_issue     = (state == c_rreq) && job_free;
	assign fifo_pop_o   = (state == c_drain) && !fifo_empty_i;
	assign fill_o       = fifo_pop_o && (word_cnt == '1);	// last refill word

	// hit / miss sequencing
	// -------------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state <= c_idle;
			core_ack_o <= 1'b0;
			job_req_o <= 1'b0;
			word_cnt <= '0;
		end else begin
			case (state)
				c_idle: if (serve) begin
					word_cnt <= '0;
					if (hit_i)
						state <= c_ack;
					else if (victim_valid_i && victim_dirty_i)
						state <= c_wb;	// flush victim first
					else
						state <= c_rreq;
				end
				c_wb: begin
					if (wb_issue) begin
						job_req_o <= 1'b1;
					end else if (job_req_o && job_ack_i) begin
						job_req_o <= 1'b0;
						word_cnt <= word_cnt + 1'b1;	// wraps to 0 for the refill
						if (word_cnt == '1)
							state <= c_rreq;
					end
				end
				c_rreq: begin
					if (rf_issue) begin
						job_req_o <= 1'b1;
					end else if (job_req_o && job_ack_i) begin
						job_req_o <= 1'b0;
						state <= c_drain;	// words arrive through the fifo
					end
				end
				c_drain: if (fifo_pop_o) begin
					word_cnt <= word_cnt + 1'b1;
					if (word_cnt == '1)
						state <= c_idle;	// re-lookup now hits
				end
				c_ack: begin
					if (!core_ack_o)
						core_ack_o <= 1'b1;
					else if (!core_req_i) begin
						core_ack_o <= 1'b0;
						state <= c_idle;
					end
				end
				default: state <= c_idle;
			endcase
		end
	end

	// data array and job payload
	// -------------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (line_hit) begin
			if (core_cmd_i.rw)
				data_mem[hit_line_i][req_offset] <= core_cmd_i.wdata;
			core_rdata_o <= data_mem[hit_line_i][req_offset];
		end
		if (fifo_pop_o)
			data_mem[victim_line_i][word_cnt] <= fifo_data_i;
		if (wb_issue) begin
			job_o.kind <= job_write;
			job_o.addr.fields.tag <= victim_tag_i;	// old line address
			job_o.addr.fields.offset <= word_cnt;
			job_o.wdata <= data_mem[victim_line_i][word_cnt];
		end
		if (rf_issue) begin
			job_o.kind <= job_refill;
			job_o.addr.fields.tag <= core_cmd_i.addr.fields.tag;
			job_o.addr.fields.offset <= '0;
			job_o.wdata <= '0;
		end
	end

endmodule

/* logic/mem_port.sv */
module mem_port
	import cache_pkg::*;
(
	input  logic     clock_i,
	input  logic     resetn_i,
	// jobs from the controller
	input  logic     job_req_i,
	input  job_t     job_i,
	output logic     job_ack_o,
	// refill words toward the fifo
	input  logic     fifo_full_i,
	output logic     fifo_push_o,
	output word_t    fifo_data_o,
	// external memory, one word per transaction
	output logic     mem_req_o,
	output mem_cmd_t mem_cmd_o,
	input  logic     mem_ack_i,
	input  word_t    mem_rdata_i
);

	typedef enum logic [1:0] {p_idle, p_fetch, p_req, p_rel} port_state_t;

	port_state_t state;
	logic        take_job;	// job latched this edge
	logic        last_word;	// nothing left after this transaction

	assign take_job  = (state == p_idle) && job_req_i && !job_ack_o;
	assign last_word = mem_cmd_o.rw || (mem_cmd_o.addr.fields.offset == '1);

	// -------------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state <= p_idle;
			job_ack_o <= 1'b0;
			mem_req_o <= 1'b0;
			fifo_push_o <= 1'b0;
		end else begin
			fifo_push_o <= 1'b0;	// strobe
			if (job_ack_o && !job_req_i)
				job_ack_o <= 1'b0;	// controller let go
			case (state)
				p_idle: if (take_job) begin
					if (job_i.kind == job_write) begin
						mem_req_o <= 1'b1;
						state <= p_req;
					end else begin
						job_ack_o <= 1'b1;	// refill acked early, words follow
						state <= p_fetch;
					end
				end
				p_fetch: if (!fifo_full_i) begin	// wait for a free slot
					mem_req_o <= 1'b1;
					state <= p_req;
				end
				p_req: if (mem_ack_i) begin
					mem_req_o <= 1'b0;
					if (mem_cmd_o.rw)
						job_ack_o <= 1'b1;	// write has landed
					else
						fifo_push_o <= 1'b1;
					state <= p_rel;
				end
				p_rel: if (!mem_ack_i) begin	// memory closed the handshake
					state <= last_word ? p_idle : p_fetch;
				end
				default: state <= p_idle;
			endcase
		end
	end

	// command and read data
	always_ff @(posedge clock_i) begin
		if (take_job) begin
			mem_cmd_o.rw <= (job_i.kind == job_write);
			mem_cmd_o.addr <= job_i.addr;
			mem_cmd_o.wdata <= job_i.wdata;
			if (job_i.kind == job_refill)
				mem_cmd_o.addr.fields.offset <= '0;	// start at line base
		end
		if ((state == p_rel) && !mem_ack_i && !last_word)
			mem_cmd_o.addr.flat <= mem_cmd_o.addr.flat + 1'b1;	// next word
		if ((state == p_req) && mem_ack_i)
			fifo_data_o <= mem_rdata_i;
	end

endmodule

/* logic/refill_fifo.sv */
module refill_fifo
	import cache_pkg::*;
#(
	parameter int depth = 2
)(
	input  logic  clock_i,
	input  logic  resetn_i,
	input  logic  push_i,
	input  word_t push_data_i,
	output logic  full_o,
	input  logic  pop_i,
	output word_t pop_data_o,	// head word, valid while not empty
	output logic  empty_o
);

	localparam int ptr_w = $clog2(depth);
	localparam int cnt_w = $clog2(depth + 1);

	word_t            slots [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;	// occupancy
	logic             do_push;
	logic             do_pop;

	assign do_push    = push_i && !full_o;
	assign do_pop     = pop_i && !empty_o;
	assign full_o     = (count == cnt_w'(depth));
	assign empty_o    = (count == '0);
	assign pop_data_o = slots[rd_ptr];

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + cnt_w'(do_push) - cnt_w'(do_pop);	// both = no change
		end
	end

	always_ff @(posedge clock_i) begin
		if (do_push)
			slots[wr_ptr] <= push_data_i;
	end

endmodule

/* logic/tag_store.sv */
module tag_store
	import cache_pkg::*;
#(
	parameter int lines = 4
)(
	input  logic                     clock_i,
	input  logic                     resetn_i,
	// associative lookup
	input  tag_t                     lookup_tag_i,
	output logic                     hit_o,
	output logic [$clog2(lines)-1:0] hit_line_o,
	input  logic                     mark_dirty_i,	// store hit
	// line fill at the victim
	input  logic                     fill_i,
	input  tag_t                     fill_tag_i,
	output logic [$clog2(lines)-1:0] victim_line_o,
	output logic                     victim_valid_o,
	output logic                     victim_dirty_o,
	output tag_t                     victim_tag_o
);

	localparam int idx_w = $clog2(lines);

	tag_t             tags [lines];
	logic [lines-1:0] valid;
	logic [lines-1:0] dirty;
	logic [idx_w-1:0] rr_ptr;	// rolling replacement pointer

	// compare against every valid line, tags are unique so at most one match
	always_comb begin
		hit_o = 1'b0;
		hit_line_o = '0;
		for (int i = 0; i < lines; i++) begin
			if (valid[i] && (tags[i] == lookup_tag_i)) begin
				hit_o = 1'b1;
				hit_line_o = idx_w'(i);
			end
		end
	end

	assign victim_line_o  = rr_ptr;
	assign victim_valid_o = valid[rr_ptr];
	assign victim_dirty_o = dirty[rr_ptr];
	assign victim_tag_o   = tags[rr_ptr];

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid <= '0;
			dirty <= '0;
			rr_ptr <= '0;
		end else begin
			if (mark_dirty_i && hit_o)
				dirty[hit_line_o] <= 1'b1;
			if (fill_i) begin
				valid[rr_ptr] <= 1'b1;
				dirty[rr_ptr] <= 1'b0;	// fresh from memory
				rr_ptr <= (rr_ptr == idx_w'(lines - 1)) ? '0 : rr_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clock_i) begin
		if (fill_i)
			tags[rr_ptr] <= fill_tag_i;
	end

endmodule

/* logic/cache_pkg.sv */
package cache_pkg;

	localparam int addr_w   = 16;	// word address
	localparam int data_w   = 32;
	localparam int offset_w = 2;	// 4 words per line
	localparam int tag_w    = addr_w - offset_w;

	typedef logic [data_w-1:0] word_t;
	typedef logic [tag_w-1:0]  tag_t;

	// tag on top, word offset below
	typedef struct packed {
		tag_t                tag;
		logic [offset_w-1:0] offset;
	} addr_fields_t;

	// one word address, flat toward memory or split for the lookup
	typedef union packed {
		logic [addr_w-1:0] flat;
		addr_fields_t      fields;
	} mem_addr_u;

	typedef struct packed {
		logic      rw;	// 1 = write
		mem_addr_u addr;
		word_t     wdata;
	} core_cmd_t;

	typedef struct packed {
		logic      rw;
		mem_addr_u addr;
		word_t     wdata;
	} mem_cmd_t;

	localparam logic job_refill = 1'b0;	// fetch a whole line
	localparam logic job_write  = 1'b1;	// write back one word

	typedef struct packed {
		logic      kind;
		mem_addr_u addr;
		word_t     wdata;	// only for job_write
	} job_t;

endpackage
